// ==== build.sh ====
#!/bin/sh
# compile and run the id stage testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert \
    --top-module tb_id_stage -Mdir obj_dir -f mips_id.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_id_stage > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Testbench failed" "$log"; then
    exit 1
fi
exit 0

// ==== mips_id.f ====
source/mips_isa_pkg.sv
source/mips_pipe_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/id_ex_reg.sv
source/id_stage.sv
tests/id_stage_properties.sv
tests/tb_id_stage.sv

// ==== source/id_ex_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
    input  wire                                 sys_clk,
    input  wire                                 rst_n,
    input  wire                                 stall_i,    // hold everything
    input  wire                                 valid_i,
    input  wire mips_pipe_pkg::dec_t            dec_i,
    input  wire [mips_isa_pkg::data_w-1:0]      rs_data_i,
    input  wire [mips_isa_pkg::data_w-1:0]      rt_data_i,
    output mips_pipe_pkg::id_ex_t               id_ex_o
);
    logic                               valid_q;
    mips_pipe_pkg::ctrl_t               ctrl_q;     // cleared on bubble
    mips_pipe_pkg::dec_t                dec_q;      // payload, ctrl field overridden
    logic [mips_isa_pkg::data_w-1:0]    rs_q;
    logic [mips_isa_pkg::data_w-1:0]    rt_q;

    // control half, reset and bubble
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
            ctrl_q  <= valid_i ? dec_i.ctrl : '0;   // no stray writes downstream
        end
    end

    // payload half
    always_ff @(posedge sys_clk) begin
        if (!stall_i) begin
            dec_q <= dec_i;
            rs_q  <= rs_data_i;
            rt_q  <= rt_data_i;
        end
    end

    always_comb begin
        id_ex_o.valid    = valid_q;
        id_ex_o.dec      = dec_q;
        id_ex_o.dec.ctrl = ctrl_q;
        id_ex_o.rs_data  = rs_q;
        id_ex_o.rt_data  = rt_q;
    end

endmodule

`default_nettype wire

// ==== source/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  wire                             sys_clk,
    input  wire                             rst_n,
    input  wire [31:0]                      instr_i,        // from fetch
    input  wire                             instr_valid_i,
    input  wire                             stall_i,        // from hazard unit
    input  wire mips_pipe_pkg::wb_write_t   wb_i,           // from writeback
    output mips_pipe_pkg::id_ex_t           id_ex_o         // to execute
);
    mips_pipe_pkg::dec_t                dec;
    logic [mips_isa_pkg::data_w-1:0]    rs_data;
    logic [mips_isa_pkg::data_w-1:0]    rt_data;

    // combinational decode
    instr_decoder u_decoder (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    // rt already points at r31 for link forms
    reg_file u_reg_file (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .rs_addr_i (dec.rs),
        .rt_addr_i (dec.rt),
        .wb_i      (wb_i),
        .stall_i   (stall_i),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    id_ex_reg u_id_ex_reg (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .stall_i   (stall_i),
        .valid_i   (instr_valid_i),
        .dec_i     (dec),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .id_ex_o   (id_ex_o)
    );

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire [31:0]          instr_i,   // fetched word
    output mips_pipe_pkg::dec_t dec_o
);
    mips_isa_pkg::opcode_e                  opcode;
    logic [mips_isa_pkg::funct_w-1:0]       func;
    logic [mips_isa_pkg::reg_addr_w-1:0]    rt_raw;     // rt before link override
    logic [mips_isa_pkg::immd_w-1:0]        immd;
    logic r_op;
    logic j_op;
    logic i_op;
    logic is_regimm;
    logic special_link;     // nal, bal
    logic special_branch;   // bal, bgez
    logic is_branch;
    logic is_load;
    logic is_store;
    logic zero_ext;
    logic rw_special;       // reg_write from the function field
    logic rw_opcode;        // reg_write from the major opcode

    // raw fields
    assign opcode = mips_isa_pkg::opcode_e'(instr_i[31:26]);
    assign func   = instr_i[5:0];
    assign rt_raw = instr_i[20:16];
    assign immd   = instr_i[15:0];

    // format
    assign r_op = opcode == mips_isa_pkg::op_special;
    assign j_op = opcode inside {mips_isa_pkg::op_j, mips_isa_pkg::op_jal};
    assign i_op = !(r_op || j_op);

    assign is_regimm      = opcode == mips_isa_pkg::op_regimm;
    assign special_link   = is_regimm && (rt_raw inside {mips_isa_pkg::rg_nal,
                                                         mips_isa_pkg::rg_bal});
    assign special_branch = is_regimm && (rt_raw inside {mips_isa_pkg::rg_bal,
                                                         mips_isa_pkg::rg_bgez});
    assign is_branch = (opcode inside {mips_isa_pkg::op_beq, mips_isa_pkg::op_bne,
                                       mips_isa_pkg::op_blez, mips_isa_pkg::op_bgtz})
                       || special_branch;

    // memory access, ll..ldc2 and sc group not handled
    assign is_load  = opcode inside {mips_isa_pkg::op_lb, mips_isa_pkg::op_lh,
                                     mips_isa_pkg::op_lwl, mips_isa_pkg::op_lw,
                                     mips_isa_pkg::op_lbu, mips_isa_pkg::op_lhu,
                                     mips_isa_pkg::op_lwr};
    assign is_store = opcode inside {mips_isa_pkg::op_sb, mips_isa_pkg::op_sh,
                                     mips_isa_pkg::op_swl, mips_isa_pkg::op_sw,
                                     mips_isa_pkg::op_swr};

    // logical immediates are zero extended
    assign zero_ext = opcode inside {mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
                                     mips_isa_pkg::op_xori, mips_isa_pkg::op_lui};

    // which instructions write a gpr
    always_comb begin
        case (func) inside
            mips_isa_pkg::fn_sll, mips_isa_pkg::fn_srl, mips_isa_pkg::fn_sra,
            mips_isa_pkg::fn_sllv, mips_isa_pkg::fn_srlv, mips_isa_pkg::fn_srav:
                rw_special = 1'b1;                  // shifts
            mips_isa_pkg::fn_jalr, mips_isa_pkg::fn_mul, mips_isa_pkg::fn_div:
                rw_special = 1'b1;
            [mips_isa_pkg::fn_add : mips_isa_pkg::fn_nor],
            mips_isa_pkg::fn_slt, mips_isa_pkg::fn_sltu:
                rw_special = 1'b1;                  // alu ops
            default:
                rw_special = 1'b0;                  // jr, sync, unknown
        endcase
        case (opcode) inside
            mips_isa_pkg::op_jal:                               rw_opcode = 1'b1;
            [mips_isa_pkg::op_addi : mips_isa_pkg::op_lui]:     rw_opcode = 1'b1;
            default:                                            rw_opcode = is_load;
        endcase
    end

    always_comb begin
        dec_o.opcode    = opcode;
        dec_o.shift_amt = instr_i[10:6];
        dec_o.func      = func;
        dec_o.j_addr    = j_op ? instr_i[25:0] : '0;
        dec_o.rs        = instr_i[25:21];
        dec_o.rt        = (opcode == mips_isa_pkg::op_jal || special_link)
                          ? mips_isa_pkg::link_reg : rt_raw;     // link target
        dec_o.rd        = instr_i[15:11];
        if (zero_ext)
            dec_o.ext_immd = {{(mips_isa_pkg::data_w-mips_isa_pkg::immd_w){1'b0}}, immd};
        else
            dec_o.ext_immd = {{(mips_isa_pkg::data_w-mips_isa_pkg::immd_w){immd[15]}}, immd};

        // classification
        dec_o.r_op          = r_op;
        dec_o.i_op          = i_op;
        dec_o.j_op          = j_op;
        dec_o.is_jr         = r_op && (func inside {mips_isa_pkg::fn_jr, mips_isa_pkg::fn_jalr});
        dec_o.is_jump       = j_op || dec_o.is_jr;                 // j, jal, jr, jalr
        dec_o.is_jal        = opcode == mips_isa_pkg::op_jal || special_link
                              || (r_op && func == mips_isa_pkg::fn_jalr);
        dec_o.is_branch     = is_branch;
        dec_o.is_regimm     = is_regimm;
        dec_o.is_load_store = is_load || is_store;
        dec_o.is_sync       = r_op && func == mips_isa_pkg::fn_sync;
        dec_o.sync_type     = instr_i[10:6];                       // stype in shamt slot

        // controller
        dec_o.ctrl.reg_dst    = r_op;
        dec_o.ctrl.alu_src    = i_op && !is_branch;
        dec_o.ctrl.mem_to_reg = is_load;
        dec_o.ctrl.mem_write  = is_store;
        dec_o.ctrl.reg_write  = (r_op && rw_special) || rw_opcode || special_link;
    end

endmodule

`default_nettype wire

// ==== source/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // field widths of the 32-bit instruction word
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int shamt_w    = 5;   // also the sync stype field
    localparam int immd_w     = 16;
    localparam int j_addr_w   = 26;

    // register file geometry
    localparam int reg_addr_w = 5;
    localparam int data_w     = 32;
    localparam int num_regs   = 32;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31; // ra, target of jal/nal/bal

    // major opcodes, bits 31:26
    typedef enum logic [opcode_w-1:0] {
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05, op_blez  = 6'h06, op_bgtz  = 6'h07,
        op_addi    = 6'h08, op_addiu  = 6'h09, op_slti  = 6'h0a, op_sltiu = 6'h0b,
        op_andi    = 6'h0c, op_ori    = 6'h0d, op_xori  = 6'h0e, op_lui   = 6'h0f,
        op_lb      = 6'h20, op_lh     = 6'h21, op_lwl   = 6'h22, op_lw    = 6'h23,
        op_lbu     = 6'h24, op_lhu    = 6'h25, op_lwr   = 6'h26,
        op_sb      = 6'h28, op_sh     = 6'h29, op_swl   = 6'h2a, op_sw    = 6'h2b,
        op_swr     = 6'h2e
    } opcode_e;

    // special function field, bits 5:0
    typedef enum logic [funct_w-1:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03,
        fn_sllv = 6'h04, fn_srlv = 6'h06, fn_srav = 6'h07,
        fn_jr   = 6'h08, fn_jalr = 6'h09, fn_sync = 6'h0f,
        fn_mul  = 6'h18, fn_div  = 6'h1a,   // r6 sop30 / sop32
        fn_add  = 6'h20, fn_addu = 6'h21, fn_sub  = 6'h22, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25, fn_xor  = 6'h26, fn_nor  = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    // regimm selectors, carried in the rt field
    typedef enum logic [reg_addr_w-1:0] {
        rg_bgez = 5'b00001,
        rg_nal  = 5'b10000,  // link, no branch
        rg_bal  = 5'b10001   // bgez r0 with link
    } regimm_e;

endpackage

`default_nettype wire

// ==== source/mips_pipe_pkg.sv ====
`default_nettype none

package mips_pipe_pkg;

    // write request coming back from writeback, 38 bits
    typedef struct packed {
        logic                                  we;
        logic [mips_isa_pkg::reg_addr_w-1:0]   addr;
        logic [mips_isa_pkg::data_w-1:0]       data;
    } wb_write_t;

    // datapath control bits for the later stages
    typedef struct packed {
        logic mem_to_reg;  // load result goes to reg
        logic mem_write;   // store
        logic alu_src;     // 1 immediate, 0 rt operand
        logic reg_write;
        logic reg_dst;     // 1 rd, 0 rt
    } ctrl_t;

    // everything the decoder knows about one instruction
    typedef struct packed {
        mips_isa_pkg::opcode_e                 opcode;
        logic [mips_isa_pkg::shamt_w-1:0]      shift_amt;
        logic [mips_isa_pkg::funct_w-1:0]      func;
        logic [mips_isa_pkg::j_addr_w-1:0]     j_addr;     // zero unless j/jal
        logic [mips_isa_pkg::reg_addr_w-1:0]   rs;
        logic [mips_isa_pkg::reg_addr_w-1:0]   rt;         // 31 for link forms
        logic [mips_isa_pkg::reg_addr_w-1:0]   rd;
        logic [mips_isa_pkg::data_w-1:0]       ext_immd;
        logic r_op, i_op, j_op;
        logic is_jump, is_jal, is_jr, is_branch;
        logic is_regimm, is_load_store, is_sync;
        logic [mips_isa_pkg::shamt_w-1:0]      sync_type;
        ctrl_t                                 ctrl;
    } dec_t;

    // id/ex payload
    typedef struct packed {
        logic                                  valid;
        dec_t                                  dec;
        logic [mips_isa_pkg::data_w-1:0]       rs_data;
        logic [mips_isa_pkg::data_w-1:0]       rt_data;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                                     sys_clk,
    input  wire                                     rst_n,
    input  wire [mips_isa_pkg::reg_addr_w-1:0]      rs_addr_i,
    input  wire [mips_isa_pkg::reg_addr_w-1:0]      rt_addr_i,
    input  wire mips_pipe_pkg::wb_write_t           wb_i,       // from writeback
    input  wire                                     stall_i,
    output logic [mips_isa_pkg::data_w-1:0]         rs_data_o,
    output logic [mips_isa_pkg::data_w-1:0]         rt_data_o
);
    logic [mips_isa_pkg::data_w-1:0] regs [mips_isa_pkg::num_regs];
    logic                            wr_en;

    // r0 never written, stall drops the write
    assign wr_en = wb_i.we && (wb_i.addr != '0) && !stall_i;

    // async read, no bypass of a same-cycle write
    // r0 forced to zero
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_isa_pkg::num_regs; i++) begin
                regs[i] <= '0;      // whole file reads zero after reset
            end
        end else if (wr_en) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== tests/id_golden.txt ====
// test instr valid stall wb_we wb_addr wb_data ctrl flags rt ext_immd j_addr rs_data rt_data
// hex; flags = valid r_op i_op j_op jump jal jr branch regimm load_store sync
1 00221821 1 0 0 00 00000000 03 600 02 00001821 0000000 00000000 00000000
1 03fe1821 1 0 0 00 00000000 03 600 1e 00001821 0000000 00000000 00000000
2 00000000 0 0 1 01 12345678 00 200 00 00000000 0000000 00000000 00000000
2 00000000 0 0 1 02 cafef00d 00 200 00 00000000 0000000 00000000 00000000
2 00000000 0 0 1 00 deadbeef 00 200 00 00000000 0000000 00000000 00000000
2 00000000 0 0 1 05 80000001 00 200 00 00000000 0000000 00000000 00000000
2 00221821 1 0 0 00 00000000 03 600 02 00001821 0000000 12345678 cafef00d
2 00a01821 1 0 0 00 00000000 03 600 00 00001821 0000000 80000001 00000000
3 342400ff 1 0 0 00 00000000 06 500 04 000000ff 0000000 12345678 00000000
3 8c46fffc 1 0 0 00 00000000 16 502 06 fffffffc 0000000 cafef00d 00000000
3 ac250008 1 0 0 00 00000000 0c 502 05 00000008 0000000 12345678 80000001
3 1022fffe 1 0 0 00 00000000 00 508 02 fffffffe 0000000 12345678 cafef00d
3 08100040 1 0 0 00 00000000 00 4c0 10 00000040 0100040 00000000 00000000
4 30278001 1 0 0 00 00000000 06 500 07 00008001 0000000 12345678 00000000
4 3c08abcd 1 0 0 00 00000000 06 500 08 0000abcd 0000000 00000000 00000000
4 20a9ffff 1 0 0 00 00000000 06 500 09 ffffffff 0000000 80000001 00000000
4 14a0fff0 1 0 0 00 00000000 00 508 00 fffffff0 0000000 80000001 00000000
4 0c000010 1 0 0 00 00000000 02 4e0 1f 00000010 0000010 00000000 00000000
4 04100004 1 0 0 00 00000000 06 524 1f 00000004 0000000 00000000 00000000
4 0411fff8 1 0 0 00 00000000 02 52c 1f fffffff8 0000000 00000000 00000000
5 00221821 1 0 0 00 00000000 03 600 02 00001821 0000000 12345678 cafef00d
5 342400ff 1 1 1 01 11111111 03 600 02 00001821 0000000 12345678 cafef00d
5 00000000 0 1 0 00 00000000 03 600 02 00001821 0000000 12345678 cafef00d
5 00221821 1 0 0 00 00000000 03 600 02 00001821 0000000 12345678 cafef00d
6 8c46fffc 0 0 0 00 00000000 00 102 06 fffffffc 0000000 cafef00d 00000000
6 ac250008 0 0 0 00 00000000 00 102 05 00000008 0000000 12345678 80000001

// ==== tests/id_stage_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage_properties (
    input wire                          sys_clk,
    input wire                          rst_n,
    input wire                          stall_i,
    input wire mips_pipe_pkg::id_ex_t   id_ex_i     // stage output under watch
);

    // nothing valid leaves the stage straight after reset
    reset_clears: assert property (@(posedge sys_clk)
        !rst_n |=> (!id_ex_i.valid && id_ex_i.dec.ctrl == '0))
        else $error("id_ex valid or ctrl set after reset");

    // a stalled edge leaves the payload untouched
    stall_holds: assert property (@(posedge sys_clk)
        (rst_n && stall_i) |=> $stable(id_ex_i))
        else $error("id_ex changed across a stall");

    load_store_mutex: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(id_ex_i.dec.ctrl.mem_to_reg && id_ex_i.dec.ctrl.mem_write))
        else $error("mem_to_reg and mem_write both high");

    // bubbles must not write anything downstream
    bubble_no_write: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !id_ex_i.valid |-> !id_ex_i.dec.ctrl.reg_write)
        else $error("bubble carries reg_write");

endmodule

bind id_stage id_stage_properties u_props (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .stall_i (stall_i),
    .id_ex_i (id_ex_o)
);

`default_nettype wire

// ==== tests/tb_id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;

    localparam int vec_words    = 14;   // hex words per golden line
    localparam int max_vecs     = 64;
    localparam int reset_cycles = 8;

    logic                       sys_clk;
    logic                       rst_n;
    logic [31:0]                instr;
    logic                       instr_valid;
    logic                       stall;
    mips_pipe_pkg::wb_write_t   wb;
    mips_pipe_pkg::id_ex_t      id_ex;

    logic [31:0] golden [vec_words*max_vecs];   // all vectors back to back, 14 words each

    int num_vecs;
    int cycle_limit;
    int cycles;
    int errors;
    int checks;
    int tests_done;
    int cur_test;
    int test_errors;    // errors inside the running test

    id_stage uut (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .stall_i       (stall),
        .wb_i          (wb),
        .id_ex_o       (id_ex)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;      // 8 ns
    end

    // guard against a run that never ends
    always @(posedge sys_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, run still going after %0d clock cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // flag order matches the golden flags column
    function automatic logic [10:0] observed_flags(mips_pipe_pkg::id_ex_t p);
        return {p.valid, p.dec.r_op, p.dec.i_op, p.dec.j_op, p.dec.is_jump, p.dec.is_jal,
                p.dec.is_jr, p.dec.is_branch, p.dec.is_regimm, p.dec.is_load_store,
                p.dec.is_sync};
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Error %s expected %h got %h", name, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic apply_vector(int base);
        instr       = golden[base+1];
        instr_valid = golden[base+2][0];
        stall       = golden[base+3][0];
        wb.we       = golden[base+4][0];       // writeback port
        wb.addr     = golden[base+5][4:0];
        wb.data     = golden[base+6];
    endtask

    task automatic check_outputs(int base);
        checks += 7;
        if (id_ex.dec.ctrl != golden[base+7][4:0])
            report_mismatch("ctrl", golden[base+7], 32'(id_ex.dec.ctrl));
        if (observed_flags(id_ex) != golden[base+8][10:0])
            report_mismatch("flags", golden[base+8], 32'(observed_flags(id_ex)));
        if (id_ex.dec.rt != golden[base+9][4:0])
            report_mismatch("rt", golden[base+9], 32'(id_ex.dec.rt));
        if (id_ex.dec.ext_immd != golden[base+10])
            report_mismatch("ext_immd", golden[base+10], id_ex.dec.ext_immd);
        if (id_ex.dec.j_addr != golden[base+11][25:0])
            report_mismatch("j_addr", golden[base+11], 32'(id_ex.dec.j_addr));
        if (id_ex.rs_data != golden[base+12])
            report_mismatch("rs_data", golden[base+12], id_ex.rs_data);
        if (id_ex.rt_data != golden[base+13])
            report_mismatch("rt_data", golden[base+13], id_ex.rt_data);
    endtask

    // raw fields of the word that the payload half took in last
    task automatic check_fields(logic [31:0] word);
        checks += 6;
        if (id_ex.dec.opcode != mips_isa_pkg::opcode_e'(word[31:26]))
            report_mismatch("opcode", 32'(word[31:26]), 32'(id_ex.dec.opcode));
        if (id_ex.dec.rs != word[25:21])
            report_mismatch("rs", 32'(word[25:21]), 32'(id_ex.dec.rs));
        if (id_ex.dec.rd != word[15:11])
            report_mismatch("rd", 32'(word[15:11]), 32'(id_ex.dec.rd));
        if (id_ex.dec.shift_amt != word[10:6])
            report_mismatch("shift_amt", 32'(word[10:6]), 32'(id_ex.dec.shift_amt));
        if (id_ex.dec.sync_type != word[10:6])
            report_mismatch("sync_type", 32'(word[10:6]), 32'(id_ex.dec.sync_type));
        if (id_ex.dec.func != word[5:0])
            report_mismatch("func", 32'(word[5:0]), 32'(id_ex.dec.func));
    endtask

    task automatic close_test();
        if (test_errors == 0)
            $display("test %0d passed", cur_test);
        else
            $display("test %0d failed with %0d errors", cur_test, test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    initial begin
        int base;
        logic [31:0] rnd;
        logic [31:0] loaded_instr;

        rst_n        = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        stall        = 1'b0;
        wb           = '0;
        cycles       = 0;
        errors       = 0;
        checks       = 0;
        tests_done   = 0;
        test_errors  = 0;
        loaded_instr = '0;
        void'($urandom(32'h40aaaddb));

        for (int i = 0; i < vec_words * max_vecs; i++)
            golden[i] = '0;                     // test number 0 ends the list
        $readmemh("tests/id_golden.txt", golden);
        num_vecs = 0;
        while (num_vecs < max_vecs && golden[num_vecs*vec_words] != 32'h0)
            num_vecs++;
        cycle_limit = 4 * num_vecs + reset_cycles;
        if (num_vecs == 0) begin
            $display("no test vectors found in tests/id_golden.txt");
            errors++;
        end

        // reset has to win over junk on the inputs
        repeat (reset_cycles) begin
            @(negedge sys_clk);
            rnd         = $urandom;
            instr       = $urandom;
            instr_valid = rnd[0];
            wb.we       = rnd[1];
            wb.addr     = rnd[6:2];
            wb.data     = $urandom;
        end

        // test 0 looks at the state right out of reset
        cur_test = 0;
        checks += 2;
        if (id_ex.valid != 1'b0)
            report_mismatch("valid", 32'h0, 32'(id_ex.valid));
        if (id_ex.dec.ctrl != '0)
            report_mismatch("ctrl", 32'h0, 32'(id_ex.dec.ctrl));
        close_test();

        rst_n = 1'b1;
        for (int v = 0; v < num_vecs; v++) begin
            base = v * vec_words;
            if (v > 0 && golden[base] != cur_test)
                close_test();                   // new test number
            cur_test = golden[base];
            apply_vector(base);
            if (!stall)
                loaded_instr = instr;           // payload held while stalled
            @(negedge sys_clk);                 // one rising edge in between
            check_outputs(base);
            check_fields(loaded_instr);
        end
        if (num_vecs > 0)
            close_test();

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
